// ==== geom_xform_unit.f ====
geom_pkg.sv
vertex_lane.sv
geom_cmd_ctrl.sv
geom_coeff_gen.sv
geom_obj_packer.sv
geom_xform_unit.sv
tb_geom_xform_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the geometry transform testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_geom_xform_unit \
    -f geom_xform_unit.f \
    -o tb_geom_xform_unit

# a failing run exits non-zero, so keep going and let the log decide
./obj_dir/tb_geom_xform_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log || ! grep -q "Result: PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== tb_geom_xform_unit.sv ====
`timescale 1ns/1ns
module tb_geom_xform_unit;

    logic                                clk = 1'b0;
    logic                                rst_n;
    logic                                go;
    geom_pkg::geom_op_e                  gmt_op;
    logic [3:0]                          gmt_code;
    logic signed [geom_pkg::coord_w-1:0] v0, v1, v2, v3, v4, v5, v6, v7;
    geom_pkg::obj_type_e                 obj_type;
    logic [7:0]                          obj_color;
    geom_pkg::obj_word_t                 obj_in = '0;
    logic                                addr_vld = 1'b0;
    logic                                obj_mem_full;
    logic                                busy, ref_addr, rd_en, wr_en, crt_obj;
    geom_pkg::obj_word_t                 obj_out;

    logic [31:0]                         lfsr = 32'hdbfc7cd1;
    logic [3:0]                          vld_wait = '0;
    geom_pkg::obj_word_t                 mem_obj = '0;  // the one object in video memory
    geom_pkg::obj_word_t                 exp_obj = '0;
    geom_pkg::obj_word_t                 exp_mem = '0;  // model of mem_obj
    logic signed [geom_pkg::coord_w-1:0] cv [8];        // create data and the offset in cv[0]
    geom_pkg::obj_type_e                 c_type = geom_pkg::obj_point;
    logic [7:0]                          c_color = '0;
    logic                                write_expected = 1'b0;
    logic                                cur_create = 1'b0;
    logic                                seen_go = 1'b0;
    logic                                rd_seen = 1'b0;
    logic                                xform_cmd;

    geom_xform_unit dut (.*);

    always #50 clk = ~clk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    // small coordinates so that no stage wraps
    function automatic logic signed [15:0] rand_coord();
        logic [11:0] r;
        r = 12'(rand_bits(12));
        return {{4{r[11]}}, r};
    endfunction

    function automatic logic is_xform_op(input geom_pkg::geom_op_e op);
        return op == geom_pkg::op_trans_one || op == geom_pkg::op_trans_all ||
               op == geom_pkg::op_scale || op == geom_pkg::op_rot_left ||
               op == geom_pkg::op_rot_right;
    endfunction

    function automatic geom_pkg::obj_word_t pack_create(input geom_pkg::obj_type_e t,
                                                        input logic [7:0] col);
        geom_pkg::obj_word_t w;
        w          = '0;
        w.obj_type = t;
        w.color    = col;
        for (int i = 0; i <= int'(t); i++) begin
            w.vtx[i].x = cv[2 * i];
            w.vtx[i].y = cv[2 * i + 1];
        end
        return w;
    endfunction

    function automatic geom_pkg::obj_word_t apply_xform(input geom_pkg::obj_word_t obj,
            input geom_pkg::geom_op_e op, input logic [3:0] code, input logic signed [15:0] off);
        geom_pkg::obj_word_t res;
        longint              cx, cy, dx, dy, nx, ny, c, s, num;
        int                  sh, t;
        logic                rot;
        res     = obj;
        res.pad = '0;
        t       = int'(obj.obj_type);
        rot     = op == geom_pkg::op_rot_left || op == geom_pkg::op_rot_right;
        cx      = 0;
        cy      = 0;
        if ((op == geom_pkg::op_scale || (rot && code[3])) && t != 2) begin
            for (int i = 0; i <= t; i++) begin
                cx += obj.vtx[i].x;
                cy += obj.vtx[i].y;
            end
            cx = cx >>> (t == 3 ? 2 : t);  // mean of 1, 2 or 4 vertices
            cy = cy >>> (t == 3 ? 2 : t);
        end
        num = (code[1:0] == 2'd3) ? 2 : (code[1:0] == 2'd0) ? 1 : 3;  // 1/2 3/4 3/2 2
        sh  = (code[1:0] == 2'd1) ? 2 : (code[1:0] == 2'd3) ? 0 : 1;
        c   = geom_pkg::rot_cos_q15[code[2:0]];
        s   = geom_pkg::rot_sin_q15[code[2:0]];
        if (op == geom_pkg::op_rot_right)
            s = -s;
        for (int i = 0; i < 4; i++) begin
            dx = obj.vtx[i].x - cx;
            dy = obj.vtx[i].y - cy;
            if (rot) begin
                nx = (c * dx - s * dy) >>> geom_pkg::rot_shift;
                ny = (s * dx + c * dy) >>> geom_pkg::rot_shift;
            end else if (op == geom_pkg::op_scale) begin
                nx = (num * dx) >>> sh;
                ny = (num * dy) >>> sh;
            end else begin
                nx = dx + (code[0] ? longint'(off) : 0);
                ny = dy + (code[1] ? longint'(off) : 0);
            end
            if (i > t)
                res.vtx[i] = '0;
            else if (op != geom_pkg::op_trans_one || code[3:2] == 2'(i)) begin
                res.vtx[i].x = 16'(nx + cx);
                res.vtx[i].y = 16'(ny + cy);
            end
        end
        return res;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // memory model answers ref_addr and crt_obj after 1 to 8 cycles
    always @(posedge clk) begin
        addr_vld <= 1'b0;
        if (ref_addr || crt_obj)
            vld_wait <= 4'(rand_bits(3)) + 4'd1;
        else if (vld_wait != 4'd0) begin
            vld_wait <= vld_wait - 4'd1;
            if (vld_wait == 4'd1)
                addr_vld <= 1'b1;
        end
        if (rd_en)
            obj_in <= mem_obj;
        if (wr_en)
            mem_obj <= obj_out;
    end

    always @(posedge clk) begin
        seen_go <= seen_go || go;
        if (rd_en)
            rd_seen <= 1'b1;
        else if (wr_en)
            rd_seen <= 1'b0;
    end

    assign xform_cmd = is_xform_op(gmt_op);

    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_go && !go |-> !(busy || rd_en || wr_en || ref_addr || crt_obj))
        else fail_run("control output active before the first command");
    a_create_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        go && !busy && gmt_op == geom_pkg::op_create && !obj_mem_full |-> crt_obj)
        else fail_run("crt_obj missing for an accepted create");
    a_xform_req: assert property (@(posedge clk) disable iff (!rst_n)
        go && !busy && xform_cmd |-> ref_addr)
        else fail_run("ref_addr missing for a transform command");
    a_ignored: assert property (@(posedge clk) disable iff (!rst_n)
        go && !busy && !xform_cmd && !(gmt_op == geom_pkg::op_create && !obj_mem_full)
        |-> !crt_obj && !ref_addr ##1 !busy)
        else fail_run("an ignored command started the DUT");
    a_write_expected: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> write_expected)
        else fail_run("wr_en without an accepted command");
    a_obj_out: assert property (@(posedge clk) disable iff (!rst_n) wr_en |-> obj_out == exp_obj)
        else fail_run($sformatf("MISMATCH obj_out got %h expected %h",
                                $sampled(obj_out), $sampled(exp_obj)));
    a_rd_order: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> addr_vld && busy && !cur_create)
        else fail_run("rd_en came without addr_vld or outside a transform");
    a_wr_order: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> addr_vld && (cur_create || rd_seen))
        else fail_run("wr_en came without a prior rd_en or without addr_vld");
    a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n) busy && !wr_en |=> busy)
        else fail_run("busy dropped before wr_en");
    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n) wr_en |=> !busy)
        else fail_run("busy still high in the cycle after wr_en");

    task automatic issue(input geom_pkg::geom_op_e op, input logic [3:0] code, input logic full);
        logic accepted;
        accepted = is_xform_op(op) || (op == geom_pkg::op_create && !full);
        @(posedge clk);
        go             <= 1'b1;
        gmt_op         <= op;
        gmt_code       <= code;
        obj_mem_full   <= full;
        obj_type       <= c_type;
        obj_color      <= c_color;
        {v7, v6, v5, v4, v3, v2, v1, v0} <= {cv[7], cv[6], cv[5], cv[4],
                                             cv[3], cv[2], cv[1], cv[0]};
        write_expected <= accepted;
        cur_create     <= op == geom_pkg::op_create;
        @(posedge clk);
        go <= 1'b0;
        if (accepted) begin
            do
                @(negedge clk);
            while (!wr_en);
            exp_mem = exp_obj;
        end
        @(negedge clk);
    endtask

    task automatic create_obj(input geom_pkg::obj_type_e t, input logic full);
        for (int i = 0; i < 8; i++)
            cv[i] = rand_coord();
        c_type  = t;
        c_color = 8'(rand_bits(8));
        exp_obj = pack_create(t, c_color);
        issue(geom_pkg::op_create, 4'(rand_bits(4)), full);
    endtask

    task automatic transform(input geom_pkg::geom_op_e op, input logic [3:0] code);
        cv[0]   = rand_coord();  // offset on v0
        exp_obj = apply_xform(exp_mem, op, code, cv[0]);
        issue(op, code, 1'b0);
    endtask

    initial begin
        rst_n        <= 1'b0;
        go           <= 1'b0;
        gmt_op       <= geom_pkg::op_create;
        gmt_code     <= '0;
        {v7, v6, v5, v4, v3, v2, v1, v0} <= 128'd0;
        obj_type     <= geom_pkg::obj_point;
        obj_color    <= '0;
        obj_mem_full <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        for (int t = 0; t < 4; t++)
            create_obj(geom_pkg::obj_type_e'(t), 1'b0);
        create_obj(geom_pkg::obj_quad, 1'b1);          // dropped while the memory is full
        issue(geom_pkg::geom_op_e'(4'd2), 4'd0, 1'b0);  // unknown codes
        issue(geom_pkg::geom_op_e'(4'd11), 4'd5, 1'b0);
        for (int t = 0; t < 4; t++) begin
            for (int sel = 0; sel < 4; sel++) begin
                create_obj(geom_pkg::obj_type_e'(t), 1'b0);
                transform(geom_pkg::op_trans_one, {2'(sel), 2'(rand_bits(2))});
            end
            create_obj(geom_pkg::obj_type_e'(t), 1'b0);
            transform(geom_pkg::op_trans_all, 4'(rand_bits(4)));
            for (int f = 0; f < 4; f++) begin
                create_obj(geom_pkg::obj_type_e'(t), 1'b0);
                transform(geom_pkg::op_scale, {2'(rand_bits(2)), 2'(f)});
            end
        end
        // code bit 3 picks the centroid and bits 2:0 the angle
        for (int d = 0; d < 2; d++) begin
            for (int k = 0; k < 16; k++) begin
                create_obj(geom_pkg::obj_type_e'(2'(rand_bits(2))), 1'b0);
                transform(d == 0 ? geom_pkg::op_rot_left : geom_pkg::op_rot_right, 4'(k));
            end
        end
        $display("Result: PASSED");
        $finish;
    end

    // 143 commands at 40 cycles each plus the reset
    initial begin
        repeat ((7 + 2 * 16 + 2 * 4 + 2 * 16 + 2 * 32) * 40 + 12) @(posedge clk);
        fail_run("timeout, the DUT did not finish its commands in time");
    end

endmodule

// ==== geom_xform_unit.sv ====
`timescale 1ns/1ns
module geom_xform_unit (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                go,
    input  geom_pkg::geom_op_e                  gmt_op,
    input  logic [3:0]                          gmt_code,
    input  logic signed [geom_pkg::coord_w-1:0] v0, v1, v2, v3, v4, v5, v6, v7,
    input  geom_pkg::obj_type_e                 obj_type,
    input  logic [7:0]                          obj_color,
    input  geom_pkg::obj_word_t                 obj_in,
    input  logic                                addr_vld,
    input  logic                                obj_mem_full,
    output logic                                busy,
    output logic                                ref_addr,
    output logic                                rd_en,
    output logic                                wr_en,
    output logic                                crt_obj,
    output geom_pkg::obj_word_t                 obj_out
);

    logic                                            load_obj;
    logic                                            calc_start;
    logic                                            create_ld;
    logic                                            pack_done;
    logic                                            lane_valid;
    geom_pkg::xform_coeff_t                          coeff;
    geom_pkg::vertex_t [geom_pkg::num_vertices-1:0]  lane_vertex;
    geom_pkg::vertex_t [geom_pkg::num_vertices-1:0]  lane_vout;
    logic [geom_pkg::num_vertices-1:0]               lane_touch;
    logic [geom_pkg::num_vertices-1:0]               lane_out_valid;
    geom_pkg::vertex_t                               centroid;
    logic [7:0]                                      obj_color_q;
    geom_pkg::obj_type_e                             obj_type_q;

    geom_cmd_ctrl u_ctrl (
        .clk, .rst_n, .go, .gmt_op, .obj_mem_full, .addr_vld, .pack_done,
        .busy, .ref_addr, .rd_en, .wr_en, .crt_obj, .load_obj, .calc_start, .create_ld
    );

    geom_coeff_gen u_coeff (
        .clk, .rst_n, .gmt_op, .gmt_code, .v0, .obj_in, .load_obj, .calc_start,
        .coeff, .lane_vertex, .lane_touch, .lane_valid, .centroid, .obj_color_q, .obj_type_q
    );

    // one lane per vertex slot, all run in lock step
    for (genvar i = 0; i < geom_pkg::num_vertices; i++) begin : g_lane
        vertex_lane u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .lane_valid (lane_valid),
            .coeff      (coeff),
            .vin        (lane_vertex[i]),
            .touch      (lane_touch[i]),
            .vout       (lane_vout[i]),
            .out_valid  (lane_out_valid[i])
        );
    end

    geom_obj_packer u_packer (
        .clk, .rst_n,
        .out_valid (lane_out_valid),
        .lane_vout, .centroid, .obj_color_q, .obj_type_q, .create_ld,
        .v0, .v1, .v2, .v3, .v4, .v5, .v6, .v7, .obj_type, .obj_color,
        .obj_out, .pack_done
    );

endmodule

// ==== geom_obj_packer.sv ====
`timescale 1ns/1ns
module geom_obj_packer (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [geom_pkg::num_vertices-1:0]               out_valid,
    input  geom_pkg::vertex_t [geom_pkg::num_vertices-1:0]  lane_vout,
    input  geom_pkg::vertex_t                               centroid,
    input  logic [7:0]                                      obj_color_q,
    input  geom_pkg::obj_type_e                             obj_type_q,
    input  logic                                            create_ld,
    input  logic signed [geom_pkg::coord_w-1:0]             v0, v1, v2, v3, v4, v5, v6, v7,
    input  geom_pkg::obj_type_e                             obj_type,
    input  logic [7:0]                                      obj_color,
    output geom_pkg::obj_word_t                             obj_out,
    output logic                                            pack_done
);

    geom_pkg::vertex_t [geom_pkg::num_vertices-1:0] crt_vtx;
    logic                                           lanes_done;

    assign crt_vtx    = {v7, v6, v5, v4, v3, v2, v1, v0};  // y above x in each slot
    assign lanes_done = &out_valid;

    always_ff @(posedge clk) begin
        if (create_ld) begin
            obj_out.obj_type <= obj_type;
            obj_out.pad      <= '0;
            obj_out.color    <= obj_color;
            for (int i = 0; i < geom_pkg::num_vertices; i++)
                obj_out.vtx[i] <= (i <= int'(obj_type)) ? crt_vtx[i] : '0;
        end else if (lanes_done) begin
            obj_out.obj_type <= obj_type_q;
            obj_out.pad      <= '0;
            obj_out.color    <= obj_color_q;
            for (int i = 0; i < geom_pkg::num_vertices; i++) begin
                // put the centroid back, zero the unused slots
                obj_out.vtx[i].x <= (i <= int'(obj_type_q)) ? lane_vout[i].x + centroid.x : '0;
                obj_out.vtx[i].y <= (i <= int'(obj_type_q)) ? lane_vout[i].y + centroid.y : '0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pack_done <= 1'b0;
        else
            pack_done <= lanes_done;
    end

endmodule

// ==== geom_coeff_gen.sv ====
`timescale 1ns/1ns
module geom_coeff_gen (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  geom_pkg::geom_op_e                              gmt_op,
    input  logic [3:0]                                      gmt_code,
    input  logic signed [geom_pkg::coord_w-1:0]             v0,
    input  geom_pkg::obj_word_t                             obj_in,
    input  logic                                            load_obj,
    input  logic                                            calc_start,
    output geom_pkg::xform_coeff_t                          coeff,
    output geom_pkg::vertex_t [geom_pkg::num_vertices-1:0]  lane_vertex,
    output logic [geom_pkg::num_vertices-1:0]               lane_touch,
    output logic                                            lane_valid,
    output geom_pkg::vertex_t                               centroid,
    output logic [7:0]                                      obj_color_q,
    output geom_pkg::obj_type_e                             obj_type_q
);

    geom_pkg::obj_word_t                 obj_q;
    geom_pkg::vertex_t                   cen;
    geom_pkg::xform_coeff_t              cf;
    logic                                use_cen;
    logic signed [geom_pkg::coord_w:0]   sum2_x, sum2_y;
    logic signed [geom_pkg::coord_w+1:0] sum4_x, sum4_y;
    logic signed [geom_pkg::coord_w-1:0] cos_k, sin_k;

    always_ff @(posedge clk) begin
        if (load_obj)
            obj_q <= obj_in;
    end

    assign obj_color_q = obj_q.color;
    assign obj_type_q  = obj_q.obj_type;

    // scale always works around the centroid, rotation only with code[3]
    assign use_cen = gmt_op == geom_pkg::op_scale ||
                     ((gmt_op == geom_pkg::op_rot_left || gmt_op == geom_pkg::op_rot_right) &&
                      gmt_code[3]);

    assign sum2_x = obj_q.vtx[0].x + obj_q.vtx[1].x;
    assign sum2_y = obj_q.vtx[0].y + obj_q.vtx[1].y;
    assign sum4_x = obj_q.vtx[0].x + obj_q.vtx[1].x + obj_q.vtx[2].x + obj_q.vtx[3].x;
    assign sum4_y = obj_q.vtx[0].y + obj_q.vtx[1].y + obj_q.vtx[2].y + obj_q.vtx[3].y;

    always_comb begin
        cen = '0;
        if (use_cen) begin
            case (obj_q.obj_type)
                geom_pkg::obj_point: cen = obj_q.vtx[0];
                geom_pkg::obj_line: begin
                    cen.x = sum2_x[geom_pkg::coord_w:1];
                    cen.y = sum2_y[geom_pkg::coord_w:1];
                end
                geom_pkg::obj_quad: begin
                    cen.x = sum4_x[geom_pkg::coord_w+1:2];
                    cen.y = sum4_y[geom_pkg::coord_w+1:2];
                end
                default: cen = '0;  // a triangle would need a divide by 3
            endcase
        end
    end

    assign cos_k = geom_pkg::rot_cos_q15[gmt_code[2:0]];
    assign sin_k = geom_pkg::rot_sin_q15[gmt_code[2:0]];

    always_comb begin
        cf     = '0;
        cf.c11 = 16'sd1;  // identity unless the op says otherwise
        cf.c22 = 16'sd1;
        case (gmt_op)
            geom_pkg::op_trans_one, geom_pkg::op_trans_all: begin
                cf.c13 = gmt_code[0] ? v0 : 16'sd0;
                cf.c23 = gmt_code[1] ? v0 : 16'sd0;
            end
            geom_pkg::op_scale: begin
                case (gmt_code[1:0])
                    2'd0: {cf.c11, cf.shift} = {16'sd1, 4'd1};  // 1/2
                    2'd1: {cf.c11, cf.shift} = {16'sd3, 4'd2};  // 3/4
                    2'd2: {cf.c11, cf.shift} = {16'sd3, 4'd1};  // 3/2
                    default: {cf.c11, cf.shift} = {16'sd2, 4'd0};
                endcase
                cf.c22 = cf.c11;
            end
            geom_pkg::op_rot_left, geom_pkg::op_rot_right: begin
                cf.c11   = cos_k;
                cf.c22   = cos_k;
                cf.c12   = (gmt_op == geom_pkg::op_rot_left) ? -sin_k : sin_k;
                cf.c21   = -cf.c12;
                cf.shift = 4'(geom_pkg::rot_shift);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (calc_start) begin
            coeff    <= cf;
            centroid <= cen;
            for (int i = 0; i < geom_pkg::num_vertices; i++) begin
                lane_vertex[i].x <= obj_q.vtx[i].x - cen.x;
                lane_vertex[i].y <= obj_q.vtx[i].y - cen.y;
                lane_touch[i]    <= (i <= int'(obj_q.obj_type)) &&
                                    (gmt_op != geom_pkg::op_trans_one ||
                                     gmt_code[3:2] == 2'(i));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            lane_valid <= 1'b0;
        else
            lane_valid <= calc_start;
    end

    a_issue: assert property (@(posedge clk) disable iff (!rst_n) calc_start |=> lane_valid)
        else $error("lane_valid missing after calc_start");

endmodule

// ==== geom_cmd_ctrl.sv ====
`timescale 1ns/1ns
module geom_cmd_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               go,
    input  geom_pkg::geom_op_e gmt_op,
    input  logic               obj_mem_full,
    input  logic               addr_vld,
    input  logic               pack_done,
    output logic               busy,
    output logic               ref_addr,
    output logic               rd_en,
    output logic               wr_en,
    output logic               crt_obj,
    output logic               load_obj,
    output logic               calc_start,
    output logic               create_ld
);

    typedef enum logic [2:0] {
        st_idle,
        st_wait_rd,
        st_load,
        st_calc,
        st_compute,
        st_wait_wr_req,
        st_wait_wr
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   is_xform;

    assign is_xform = gmt_op inside {geom_pkg::op_trans_one, geom_pkg::op_trans_all,
                                     geom_pkg::op_scale, geom_pkg::op_rot_left,
                                     geom_pkg::op_rot_right};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt  = state;
        ref_addr   = 1'b0;
        rd_en      = 1'b0;
        wr_en      = 1'b0;
        crt_obj    = 1'b0;
        load_obj   = 1'b0;
        calc_start = 1'b0;
        case (state)
            st_idle: begin
                if (go && gmt_op == geom_pkg::op_create && !obj_mem_full) begin
                    crt_obj   = 1'b1;  // packer loads the create word on this edge
                    state_nxt = st_wait_wr;
                end else if (go && is_xform) begin
                    ref_addr  = 1'b1;  // ask the object unit for the address
                    state_nxt = st_wait_rd;
                end
            end
            st_wait_rd: begin
                if (addr_vld) begin
                    rd_en     = 1'b1;
                    state_nxt = st_load;
                end
            end
            st_load: begin
                load_obj  = 1'b1;  // obj_in is valid now
                state_nxt = st_calc;
            end
            st_calc: begin
                calc_start = 1'b1;
                state_nxt  = st_compute;
            end
            st_compute: begin
                if (pack_done)
                    state_nxt = st_wait_wr_req;
            end
            st_wait_wr_req: begin
                ref_addr  = 1'b1;
                state_nxt = st_wait_wr;
            end
            st_wait_wr: begin
                if (addr_vld) begin
                    wr_en     = 1'b1;
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    assign busy      = (state != st_idle);
    assign create_ld = crt_obj;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && wr_en))
        else $error("rd_en and wr_en high together");

endmodule

// ==== vertex_lane.sv ====
`timescale 1ns/1ns
module vertex_lane (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   lane_valid,
    input  geom_pkg::xform_coeff_t coeff,
    input  geom_pkg::vertex_t      vin,
    input  logic                   touch,
    output geom_pkg::vertex_t      vout,
    output logic                   out_valid
);

    logic signed [31:0]     p11, p12, p21, p22;
    logic signed [32:0]     sum_x, sum_y;
    logic signed [32:0]     sh_x, sh_y;
    geom_pkg::xform_coeff_t coeff_q;
    geom_pkg::vertex_t      vin_q;
    logic                   touch_q;
    logic                   valid_q;

    // stage 1: products
    always_ff @(posedge clk) begin
        if (lane_valid) begin
            p11     <= vin.x * coeff.c11;
            p12     <= vin.y * coeff.c12;
            p21     <= vin.x * coeff.c21;
            p22     <= vin.y * coeff.c22;
            coeff_q <= coeff;
            vin_q   <= vin;
            touch_q <= touch;
        end
    end

    assign sum_x = p11 + p12;
    assign sum_y = p21 + p22;
    assign sh_x  = sum_x >>> coeff_q.shift;
    assign sh_y  = sum_y >>> coeff_q.shift;

    // stage 2: scale down, keep low 16 bits, add the offset
    always_ff @(posedge clk) begin
        if (valid_q) begin
            if (touch_q) begin
                vout.x <= sh_x[15:0] + coeff_q.c13;
                vout.y <= sh_y[15:0] + coeff_q.c23;
            end else begin
                vout <= vin_q;  // untouched vertex
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_q   <= lane_valid;
            out_valid <= valid_q;
        end
    end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n) lane_valid |-> ##2 out_valid)
        else $error("out_valid not two cycles after lane_valid");

endmodule

// ==== geom_pkg.sv ====
package geom_pkg;

    localparam int coord_w      = 16;
    localparam int num_vertices = 4;
    localparam int rot_shift    = 15;  // Q15 rotation terms

    // command codes on gmt_op, other codes are ignored
    typedef enum logic [3:0] {
        op_create    = 4'd0,
        op_trans_one = 4'd3,
        op_trans_all = 4'd4,
        op_scale     = 4'd5,
        op_rot_left  = 4'd6,
        op_rot_right = 4'd7
    } geom_op_e;

    // vertices 0..type are valid
    typedef enum logic [1:0] {
        obj_point = 2'd0,
        obj_line  = 2'd1,
        obj_tri   = 2'd2,
        obj_quad  = 2'd3
    } obj_type_e;

    typedef struct packed {
        logic signed [coord_w-1:0] y;
        logic signed [coord_w-1:0] x;  // x in the low half
    } vertex_t;

    // video memory layout, 144 bits
    typedef struct packed {
        obj_type_e                    obj_type;
        logic [5:0]                   pad;
        logic [7:0]                   color;
        vertex_t [num_vertices-1:0]   vtx;  // vertex 0 lowest
    } obj_word_t;

    // x' = (c11*x + c12*y) >>> shift + c13, same for y' with row 2
    typedef struct packed {
        logic signed [coord_w-1:0] c11;
        logic signed [coord_w-1:0] c12;
        logic signed [coord_w-1:0] c13;
        logic signed [coord_w-1:0] c21;
        logic signed [coord_w-1:0] c22;
        logic signed [coord_w-1:0] c23;
        logic [3:0]                shift;
    } xform_coeff_t;

    // index k is the angle k*45 degrees
    localparam logic signed [coord_w-1:0] rot_cos_q15 [8] = '{
        16'sd32767, 16'sd23170, 16'sd0, -16'sd23170,
        16'sh8000, -16'sd23170, 16'sd0, 16'sd23170  // 16'sh8000 is -1.0
    };
    localparam logic signed [coord_w-1:0] rot_sin_q15 [8] = '{
        16'sd0, 16'sd23170, 16'sd32767, 16'sd23170,
        16'sd0, -16'sd23170, -16'sd32767, -16'sd23170
    };

endpackage
